//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       = dma_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- common/dma_axi_pkg.sv
// AXI read bus definitions

package dma_axi_pkg;

    // ========================================
    // Bus widths
    // ========================================

    // Byte address on AXI and on the local port
    typedef logic [31:0] addr_t;

    // One bus word
    typedef logic [31:0] data_t;

    // Beats in a burst minus one
    typedef logic [7:0] burst_len_t;

    // Read response code
    typedef logic [1:0] resp_t;

    // ========================================
    // Burst limits and AXI encodings
    // ========================================

    localparam int unsigned BYTES_PER_BEAT = 4;
    localparam int unsigned MAX_BURST_BEATS = 16;

    localparam logic [2:0] AXI_SIZE_WORD = 3'b010;
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    // Modifiable, bufferable
    localparam logic [3:0] AXI_CACHE_DEFAULT = 4'b0011;
    localparam resp_t AXI_RESP_OKAY = 2'b00;

endpackage

//--- common/dma_job_pkg.sv
// DMA job and descriptor definitions

package dma_job_pkg;

    // ========================================
    // Descriptor layout
    // ========================================

    // Word 0 source, word 1 destination, word 2 length in bytes,
    // word 3 control (fetched, not used)
    localparam int unsigned DESC_WORDS = 4;

    // Head pointer step per finished job
    localparam int unsigned DESC_BYTES = 16;

    // Remaining or total job bytes
    typedef logic [31:0] byte_count_t;

    // Word index inside a descriptor
    typedef logic [1:0] desc_idx_t;

    // ========================================
    // State machines
    // ========================================

    typedef enum logic [2:0] {
        job_idle,
        job_fetch,
        job_burst_req,
        job_burst_data,
        job_done
    } job_state_t;

    typedef enum logic [1:0] {
        fetch_idle,
        fetch_req,
        fetch_wait,
        fetch_done
    } fetch_state_t;

endpackage

//--- dma/dma_desc_fetch.sv
// DMA descriptor fetch
`timescale 1ns/100ps

module dma_desc_fetch (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     fetch_go,
    input  dma_axi_pkg::addr_t       job_desc_addr,
    output logic                     desc_req,
    output dma_axi_pkg::addr_t       desc_req_addr,
    input  logic                     desc_req_grant,
    input  logic                     desc_word_valid,
    input  dma_axi_pkg::data_t       beat_data,
    output dma_axi_pkg::addr_t       desc_src,
    output dma_axi_pkg::addr_t       desc_dst,
    output dma_job_pkg::byte_count_t desc_length,
    output logic                     desc_ready
);
    import dma_axi_pkg::*;
    import dma_job_pkg::*;

    fetch_state_t state;
    desc_idx_t    word_idx;
    logic         last_word;

    // Only source, destination and length are kept
    data_t desc_buf [DESC_WORDS-1];

    assign last_word = (word_idx == desc_idx_t'(DESC_WORDS - 1));

    // One single-beat read per descriptor word
    assign desc_req      = (state == fetch_req);
    assign desc_req_addr = job_desc_addr + addr_t'(word_idx) * addr_t'(BYTES_PER_BEAT);
    assign desc_ready    = (state == fetch_done);

    // ========================================
    // Fetch sequencing
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= fetch_idle;
            word_idx <= '0;
        end else begin
            case (state)
                fetch_idle: begin
                    if (fetch_go) begin
                        word_idx <= '0;
                        state    <= fetch_req;
                    end
                end
                fetch_req: begin
                    if (desc_req_grant) begin
                        state <= fetch_wait;
                    end
                end
                fetch_wait: begin
                    if (desc_word_valid) begin
                        if (last_word) begin
                            state <= fetch_done;
                        end else begin
                            word_idx <= word_idx + 1'b1;
                            state    <= fetch_req;
                        end
                    end
                end
                fetch_done: begin
                    state <= fetch_idle;
                end
                default: begin
                    state <= fetch_idle;
                end
            endcase
        end
    end

    // Word buffer, job fields latched when the control word arrives
    always_ff @(posedge clk) begin
        if (state == fetch_wait && desc_word_valid) begin
            if (last_word) begin
                desc_src    <= desc_buf[0];
                desc_dst    <= desc_buf[1];
                desc_length <= byte_count_t'(desc_buf[2]);
            end else begin
                desc_buf[word_idx] <= beat_data;
            end
        end
    end

endmodule

//--- dma/dma_job_ctrl.sv
// DMA job controller
`timescale 1ns/100ps

module dma_job_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     dma_start,
    output logic                     fetch_go,
    input  dma_axi_pkg::addr_t       desc_src,
    input  dma_axi_pkg::addr_t       desc_dst,
    input  dma_job_pkg::byte_count_t desc_length,
    input  logic                     desc_ready,
    output logic                     burst_req,
    output dma_axi_pkg::addr_t       burst_addr,
    output dma_axi_pkg::burst_len_t  burst_len,
    input  logic                     burst_req_grant,
    input  logic                     burst_beat_valid,
    input  dma_axi_pkg::data_t       beat_data,
    input  logic                     beat_last,
    input  logic                     beat_error,
    output dma_axi_pkg::addr_t       local_mem_addr,
    output logic                     local_mem_write,
    output dma_axi_pkg::data_t       local_mem_wdata,
    output logic                     dma_busy,
    output logic                     dma_done,
    output logic                     dma_error,
    output dma_axi_pkg::addr_t       dma_head_ptr
);
    import dma_axi_pkg::*;
    import dma_job_pkg::*;

    job_state_t  state;
    addr_t       src_addr;
    addr_t       wr_addr;
    byte_count_t bytes_left;
    byte_count_t words_left;

    assign fetch_go = (state == job_idle) && dma_start;
    assign dma_busy = (state != job_idle);

    // ========================================
    // Burst sizing
    // ========================================
    assign words_left = bytes_left / byte_count_t'(BYTES_PER_BEAT);
    assign burst_req  = (state == job_burst_req);
    assign burst_addr = src_addr;
    assign burst_len  = (words_left >= byte_count_t'(MAX_BURST_BEATS)) ?
                        burst_len_t'(MAX_BURST_BEATS - 1) :
                        burst_len_t'(words_left - 1'b1);

    // ========================================
    // Job state machine and counters
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= job_idle;
            src_addr   <= '0;
            wr_addr    <= '0;
            bytes_left <= '0;
        end else begin
            case (state)
                job_idle: begin
                    if (dma_start) begin
                        state <= job_fetch;
                    end
                end
                job_fetch: begin
                    if (desc_ready) begin
                        src_addr   <= desc_src;
                        wr_addr    <= desc_dst;
                        bytes_left <= desc_length;
                        // Empty job skips the data phase
                        state <= (desc_length == '0) ? job_done : job_burst_req;
                    end
                end
                job_burst_req: begin
                    if (burst_req_grant) begin
                        state <= job_burst_data;
                    end
                end
                job_burst_data: begin
                    if (burst_beat_valid) begin
                        src_addr   <= src_addr + addr_t'(BYTES_PER_BEAT);
                        wr_addr    <= wr_addr + addr_t'(BYTES_PER_BEAT);
                        bytes_left <= bytes_left - byte_count_t'(BYTES_PER_BEAT);
                        if (beat_last) begin
                            state <= (words_left == byte_count_t'(1)) ? job_done : job_burst_req;
                        end
                    end
                end
                job_done: begin
                    state <= job_idle;
                end
                default: begin
                    state <= job_idle;
                end
            endcase
        end
    end

    // Local write one cycle after each data beat
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            local_mem_write <= 1'b0;
        end else begin
            local_mem_write <= (state == job_burst_data) && burst_beat_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (burst_beat_valid) begin
            local_mem_addr  <= wr_addr;
            local_mem_wdata <= beat_data;
        end
    end

    // ========================================
    // Status
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dma_done     <= 1'b0;
            dma_error    <= 1'b0;
            dma_head_ptr <= '0;
        end else begin
            dma_done <= (state == job_done);
            if (state == job_done) begin
                dma_head_ptr <= dma_head_ptr + addr_t'(DESC_BYTES);
            end
            // Sticky until the next job starts
            if (fetch_go) begin
                dma_error <= 1'b0;
            end else if (beat_error) begin
                dma_error <= 1'b1;
            end
        end
    end

endmodule

//--- dma/dma_read_port.sv
// AXI read port with two requesters
`timescale 1ns/100ps

module dma_read_port (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    desc_req,
    input  dma_axi_pkg::addr_t      desc_req_addr,
    output logic                    desc_req_grant,
    input  logic                    burst_req,
    input  dma_axi_pkg::addr_t      burst_addr,
    input  dma_axi_pkg::burst_len_t burst_len,
    output logic                    burst_req_grant,
    output dma_axi_pkg::addr_t      araddr,
    output dma_axi_pkg::burst_len_t arlen,
    output logic                    arvalid,
    input  logic                    arready,
    input  dma_axi_pkg::data_t      rdata,
    input  dma_axi_pkg::resp_t      rresp,
    input  logic                    rlast,
    input  logic                    rvalid,
    output logic                    rready,
    output logic                    desc_word_valid,
    output logic                    burst_beat_valid,
    output dma_axi_pkg::data_t      beat_data,
    output logic                    beat_last,
    output logic                    beat_error
);
    import dma_axi_pkg::*;

    logic owner_desc;  // set when the open read is a descriptor word
    logic rd_open;
    logic port_free;
    logic ar_fire;
    logic r_fire;

    assign port_free = !arvalid && !rd_open;
    assign ar_fire   = arvalid && arready;
    assign r_fire    = rvalid && rready;

    // ========================================
    // Read address channel
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            arvalid    <= 1'b0;
            rd_open    <= 1'b0;
            owner_desc <= 1'b0;
        end else begin
            if (ar_fire) begin
                arvalid <= 1'b0;
                rd_open <= 1'b1;
            end else if (port_free && (desc_req || burst_req)) begin
                // Descriptor wins a tie
                arvalid    <= 1'b1;
                owner_desc <= desc_req;
            end
            if (r_fire && rlast) begin
                rd_open <= 1'b0;
            end
        end
    end

    // Address and length held while arvalid waits for arready
    always_ff @(posedge clk) begin
        if (port_free) begin
            araddr <= desc_req ? desc_req_addr : burst_addr;
            arlen  <= desc_req ? burst_len_t'(0) : burst_len;
        end
    end

    assign desc_req_grant  = ar_fire && owner_desc;
    assign burst_req_grant = ar_fire && !owner_desc;

    // ========================================
    // Read data channel
    // ========================================
    assign rready           = rd_open;
    assign desc_word_valid  = r_fire && owner_desc;
    assign burst_beat_valid = r_fire && !owner_desc;
    assign beat_data        = rdata;
    assign beat_last        = rlast;
    assign beat_error       = r_fire && (rresp != AXI_RESP_OKAY);

endmodule

//--- dv/dma_assert.sv
// AXI read channel assertions
`timescale 1ns/100ps

module dma_assert (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    arvalid,
    input logic                    arready,
    input dma_axi_pkg::addr_t      araddr,
    input dma_axi_pkg::burst_len_t arlen,
    input logic                    rvalid,
    input logic                    rready,
    input logic                    rlast,
    input logic                    local_mem_write,
    input logic                    dma_busy
);

    // Open from the AR handshake to the last R handshake
    logic burst_open;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            burst_open <= 1'b0;
        end else if (arvalid && arready) begin
            burst_open <= 1'b1;
        end else if (rvalid && rready && rlast) begin
            burst_open <= 1'b0;
        end
    end

    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (arvalid && !arready) |=> (arvalid && $stable(araddr) && $stable(arlen)))
        else $error("arvalid dropped or araddr/arlen changed before arready");

    a_rready_open: assert property (@(posedge clk) disable iff (!rst_n)
        burst_open |-> rready)
        else $error("rready low while a read burst is open");

    a_write_busy: assert property (@(posedge clk) disable iff (!rst_n)
        local_mem_write |-> dma_busy)
        else $error("local_mem_write high while dma_busy is low");

endmodule

bind dma_engine_top dma_assert u_assert (
    .clk             (clk),
    .rst_n           (rst_n),
    .arvalid         (m_axi_arvalid),
    .arready         (m_axi_arready),
    .araddr          (m_axi_araddr),
    .arlen           (m_axi_arlen),
    .rvalid          (m_axi_rvalid),
    .rready          (m_axi_rready),
    .rlast           (m_axi_rlast),
    .local_mem_write (local_mem_write),
    .dma_busy        (dma_busy)
);

//--- dv/dma_tb.sv
// DMA read engine testbench
`timescale 1ns/100ps

module dma_tb;
    import dma_axi_pkg::*;

    localparam int NJOBS     = 6;
    localparam int MEM_WORDS = 4096;
    localparam int TIMEOUT   = 5000;
    localparam logic [31:0] SEED = 32'h2eca_d492;

    typedef struct packed {
        logic [31:0] desc;
        logic [31:0] src;
        logic [31:0] dst;
        logic [31:0] len;
        logic        inject;
        logic        exp_err;
    } job_t;

    logic       clk;
    logic       rst_n;
    logic       dma_start;
    addr_t      job_desc_addr;
    logic       dma_busy;
    logic       dma_done;
    logic       dma_error;
    addr_t      dma_head_ptr;
    addr_t      araddr;
    burst_len_t arlen;
    logic [2:0] arsize;
    logic [1:0] arburst;
    logic [3:0] arcache;
    logic       arvalid;
    logic       arready;
    data_t      rdata;
    resp_t      rresp;
    logic       rlast;
    logic       rvalid;
    logic       rready;
    addr_t      local_mem_addr;
    logic       local_mem_write;
    data_t      local_mem_wdata;

    // Main process state
    data_t mem [MEM_WORDS];
    job_t  job_tab [NJOBS];
    job_t  cur;
    int    errors;
    int    timeouts;

    // Memory model state
    logic [31:0] stall_seed;
    logic        ar_hs;
    logic        r_hs;
    logic        busy_q;
    addr_t       ar_addr_q;
    burst_len_t  ar_len_q;
    addr_t       rd_addr;
    int          rd_beats;
    logic        rd_err;
    int          ar_count;
    int          data_beats;
    int          wr_count;
    int          model_errors;

    dma_tb_clock u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    dma_engine_top uut (
        .clk             (clk),
        .rst_n           (rst_n),
        .dma_start       (dma_start),
        .job_desc_addr   (job_desc_addr),
        .dma_busy        (dma_busy),
        .dma_done        (dma_done),
        .dma_error       (dma_error),
        .dma_head_ptr    (dma_head_ptr),
        .m_axi_araddr    (araddr),
        .m_axi_arlen     (arlen),
        .m_axi_arsize    (arsize),
        .m_axi_arburst   (arburst),
        .m_axi_arcache   (arcache),
        .m_axi_arvalid   (arvalid),
        .m_axi_arready   (arready),
        .m_axi_rdata     (rdata),
        .m_axi_rresp     (rresp),
        .m_axi_rlast     (rlast),
        .m_axi_rvalid    (rvalid),
        .m_axi_rready    (rready),
        .local_mem_addr  (local_mem_addr),
        .local_mem_write (local_mem_write),
        .local_mem_wdata (local_mem_wdata)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic show_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        $display("MISMATCH %s: got %h expected %h", name, got, exp);
    endtask

    // ========================================
    // AXI memory model and write monitor
    // ========================================

    // Expected AR fields from the descriptor offset or the bytes already moved
    task automatic accept_ar();
        addr_t exp_addr;
        int    words_left;
        int    exp_beats;
        if (ar_count < 4) begin
            exp_addr  = cur.desc + 32'(4 * ar_count);
            exp_beats = 1;
        end else begin
            words_left = int'(cur.len / 32'd4) - data_beats;
            exp_addr   = cur.src + 32'(4 * data_beats);
            exp_beats  = (words_left > 16) ? 16 : words_left;
            if (words_left <= 0) begin
                $display("Read burst issued after the whole job length was read");
                model_errors++;
            end
        end
        if (ar_addr_q !== exp_addr) begin
            show_mismatch("araddr", ar_addr_q, exp_addr);
            model_errors++;
        end
        if (ar_len_q !== 8'(exp_beats - 1)) begin
            show_mismatch("arlen", 32'(ar_len_q), 32'(exp_beats - 1));
            model_errors++;
        end
        // Word size, INCR type and the fixed cache attributes
        if (arsize !== 3'b010) begin
            show_mismatch("arsize", 32'(arsize), 32'h2);
            model_errors++;
        end
        if (arburst !== 2'b01) begin
            show_mismatch("arburst", 32'(arburst), 32'h1);
            model_errors++;
        end
        if (arcache !== 4'b0011) begin
            show_mismatch("arcache", 32'(arcache), 32'h3);
            model_errors++;
        end
        // Error goes on the second data burst of an injecting job
        rd_err   = cur.inject && (ar_count == 5);
        rd_addr  = ar_addr_q;
        rd_beats = int'(ar_len_q) + 1;
        ar_count++;
    endtask

    task automatic check_write();
        addr_t src_a;
        addr_t exp_addr;
        data_t exp_data;
        src_a    = cur.src + 32'(4 * wr_count);
        exp_addr = cur.dst + 32'(4 * wr_count);
        exp_data = mem[src_a[13:2]];
        if (local_mem_addr !== exp_addr) begin
            show_mismatch("local_mem_addr", local_mem_addr, exp_addr);
            model_errors++;
        end
        if (local_mem_wdata !== exp_data) begin
            show_mismatch("local_mem_wdata", local_mem_wdata, exp_data);
            model_errors++;
        end
        wr_count++;
    endtask

    initial begin
        arready      = 1'b0;
        rvalid       = 1'b0;
        rdata        = '0;
        rresp        = 2'b00;
        rlast        = 1'b0;
        stall_seed   = SEED;
        ar_hs        = 1'b0;
        r_hs         = 1'b0;
        busy_q       = 1'b0;
        rd_beats     = 0;
        ar_count     = 0;
        data_beats   = 0;
        wr_count     = 0;
        model_errors = 0;
        forever begin
            @(negedge clk);
            // Per-job counters restart when the engine turns busy
            if (dma_busy && !busy_q) begin
                ar_count   = 0;
                data_beats = 0;
                wr_count   = 0;
            end
            busy_q = dma_busy;
            if (ar_hs) begin
                accept_ar();
            end
            if (r_hs) begin
                rd_addr  = rd_addr + 32'd4;
                rd_beats = rd_beats - 1;
                if (ar_count > 4) begin
                    data_beats++;
                end
            end
            if (local_mem_write) begin
                check_write();
            end
            stall_seed = xorshift32(stall_seed);
            arready    = (stall_seed[2:1] != 2'b00);
            if (rd_beats > 0 && (!rvalid || r_hs)) begin
                rvalid = (stall_seed[4:3] != 2'b00);
                rdata  = mem[rd_addr[13:2]];
                rlast  = (rd_beats == 1);
                rresp  = rd_err ? 2'b10 : 2'b00;
            end else if (rd_beats == 0) begin
                rvalid = 1'b0;
                rlast  = 1'b0;
            end
            // Handshakes that complete on the next rising edge
            ar_hs     = arvalid && arready;
            ar_addr_q = araddr;
            ar_len_q  = arlen;
            r_hs      = rvalid && rready;
        end
    end

    // ========================================
    // Job sequence
    // ========================================
    task automatic run_job(input int j);
        int cycles;
        int words;
        cur   = job_tab[j];
        words = int'(cur.len / 32'd4);
        mem[cur.desc[13:2]]         = cur.src;
        mem[cur.desc[13:2] + 12'd1] = cur.dst;
        mem[cur.desc[13:2] + 12'd2] = cur.len;
        mem[cur.desc[13:2] + 12'd3] = 32'h0;
        @(negedge clk);
        dma_start     = 1'b1;
        job_desc_addr = cur.desc;
        @(negedge clk);
        dma_start = 1'b0;
        cycles    = 0;
        while (!dma_busy && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!dma_busy) begin
            $display("Timeout waiting for dma_busy on job %0d", j);
            timeouts++;
            return;
        end
        if (dma_error !== 1'b0) begin
            $display("dma_error not cleared by dma_start on job %0d", j);
            errors++;
        end
        cycles = 0;
        while (!dma_done && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!dma_done) begin
            $display("Timeout waiting for dma_done on job %0d", j);
            timeouts++;
            return;
        end
        if (dma_busy !== 1'b0) begin
            show_mismatch("dma_busy", 32'(dma_busy), 32'h0);
            errors++;
        end
        if (dma_head_ptr !== 32'(16 * (j + 1))) begin
            show_mismatch("dma_head_ptr", dma_head_ptr, 32'(16 * (j + 1)));
            errors++;
        end
        if (dma_error !== cur.exp_err) begin
            show_mismatch("dma_error", 32'(dma_error), 32'(cur.exp_err));
            errors++;
        end
        if (wr_count != words) begin
            show_mismatch("local_mem_write count", 32'(wr_count), 32'(words));
            errors++;
        end
        if (ar_count != 4 + (words + 15) / 16) begin
            show_mismatch("AR handshake count", 32'(ar_count), 32'(4 + (words + 15) / 16));
            errors++;
        end
        @(negedge clk);
        if (dma_done !== 1'b0) begin
            $display("dma_done stayed high for more than one cycle on job %0d", j);
            errors++;
        end
    endtask

    initial begin
        logic [31:0] fill;
        int          cycles;
        dma_start     = 1'b0;
        job_desc_addr = '0;
        errors        = 0;
        timeouts      = 0;
        fill          = SEED;
        for (int i = 0; i < MEM_WORDS; i++) begin
            fill   = xorshift32(fill);
            mem[i] = fill;
        end
        // Descriptor, source, destination, bytes, inject, expected error
        job_tab[0] = '{32'h0000_0100, 32'h0000_1000, 32'h8000_0000, 32'd4, 1'b0, 1'b0};
        job_tab[1] = '{32'h0000_0110, 32'h0000_1400, 32'h8000_1000, 32'd64, 1'b0, 1'b0};
        job_tab[2] = '{32'h0000_0120, 32'h0000_1800, 32'h8000_2000, 32'd68, 1'b0, 1'b0};
        job_tab[3] = '{32'h0000_0130, 32'h0000_2000, 32'h8000_3000, 32'd200, 1'b1, 1'b1};
        job_tab[4] = '{32'h0000_0140, 32'h0000_2400, 32'h8000_4000, 32'd0, 1'b0, 1'b0};
        job_tab[5] = '{32'h0000_0150, 32'h0000_2800, 32'h8000_5000, 32'd36, 1'b0, 1'b0};
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            $display("Timeout waiting for reset release");
            timeouts++;
        end else begin
            for (int j = 0; j < NJOBS; j++) begin
                run_job(j);
                if (timeouts != 0) begin
                    break;
                end
            end
        end
        repeat (2) @(negedge clk);
        $display("Summary: %0d check errors, %0d model errors, %0d timeouts",
                 errors, model_errors, timeouts);
        if (errors == 0 && model_errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- dv/dma_tb_clock.sv
// Testbench clock and reset
`timescale 1ns/100ps

module dma_tb_clock (
    output logic clk,
    output logic rst_n
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset held for 5 cycles, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- list.f
common/dma_axi_pkg.sv
common/dma_job_pkg.sv
dma/dma_desc_fetch.sv
dma/dma_read_port.sv
dma/dma_job_ctrl.sv
verilog/dma_engine_top.sv
dv/dma_assert.sv
dv/dma_tb_clock.sv
dv/dma_tb.sv

//--- verilog/dma_engine_top.sv
// DMA read engine top
`timescale 1ns/100ps

module dma_engine_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    dma_start,
    input  dma_axi_pkg::addr_t      job_desc_addr,
    output logic                    dma_busy,
    output logic                    dma_done,
    output logic                    dma_error,
    output dma_axi_pkg::addr_t      dma_head_ptr,
    output dma_axi_pkg::addr_t      m_axi_araddr,
    output dma_axi_pkg::burst_len_t m_axi_arlen,
    output logic [2:0]              m_axi_arsize,
    output logic [1:0]              m_axi_arburst,
    output logic [3:0]              m_axi_arcache,
    output logic                    m_axi_arvalid,
    input  logic                    m_axi_arready,
    input  dma_axi_pkg::data_t      m_axi_rdata,
    input  dma_axi_pkg::resp_t      m_axi_rresp,
    input  logic                    m_axi_rlast,
    input  logic                    m_axi_rvalid,
    output logic                    m_axi_rready,
    output dma_axi_pkg::addr_t      local_mem_addr,
    output logic                    local_mem_write,
    output dma_axi_pkg::data_t      local_mem_wdata
);
    import dma_axi_pkg::*;
    import dma_job_pkg::*;

    logic        fetch_go;
    logic        desc_req;
    addr_t       desc_req_addr;
    logic        desc_req_grant;
    logic        desc_word_valid;
    addr_t       desc_src;
    addr_t       desc_dst;
    byte_count_t desc_length;
    logic        desc_ready;
    logic        burst_req;
    addr_t       burst_addr;
    burst_len_t  burst_len;
    logic        burst_req_grant;
    logic        burst_beat_valid;
    data_t       beat_data;
    logic        beat_last;
    logic        beat_error;

    // Fixed burst attributes
    assign m_axi_arsize  = AXI_SIZE_WORD;
    assign m_axi_arburst = AXI_BURST_INCR;
    assign m_axi_arcache = AXI_CACHE_DEFAULT;

    dma_desc_fetch u_desc_fetch (
        .clk             (clk),
        .rst_n           (rst_n),
        .fetch_go        (fetch_go),
        .job_desc_addr   (job_desc_addr),
        .desc_req        (desc_req),
        .desc_req_addr   (desc_req_addr),
        .desc_req_grant  (desc_req_grant),
        .desc_word_valid (desc_word_valid),
        .beat_data       (beat_data),
        .desc_src        (desc_src),
        .desc_dst        (desc_dst),
        .desc_length     (desc_length),
        .desc_ready      (desc_ready)
    );

    dma_read_port u_read_port (
        .clk              (clk),
        .rst_n            (rst_n),
        .desc_req         (desc_req),
        .desc_req_addr    (desc_req_addr),
        .desc_req_grant   (desc_req_grant),
        .burst_req        (burst_req),
        .burst_addr       (burst_addr),
        .burst_len        (burst_len),
        .burst_req_grant  (burst_req_grant),
        .araddr           (m_axi_araddr),
        .arlen            (m_axi_arlen),
        .arvalid          (m_axi_arvalid),
        .arready          (m_axi_arready),
        .rdata            (m_axi_rdata),
        .rresp            (m_axi_rresp),
        .rlast            (m_axi_rlast),
        .rvalid           (m_axi_rvalid),
        .rready           (m_axi_rready),
        .desc_word_valid  (desc_word_valid),
        .burst_beat_valid (burst_beat_valid),
        .beat_data        (beat_data),
        .beat_last        (beat_last),
        .beat_error       (beat_error)
    );

    dma_job_ctrl u_job_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .dma_start        (dma_start),
        .fetch_go         (fetch_go),
        .desc_src         (desc_src),
        .desc_dst         (desc_dst),
        .desc_length      (desc_length),
        .desc_ready       (desc_ready),
        .burst_req        (burst_req),
        .burst_addr       (burst_addr),
        .burst_len        (burst_len),
        .burst_req_grant  (burst_req_grant),
        .burst_beat_valid (burst_beat_valid),
        .beat_data        (beat_data),
        .beat_last        (beat_last),
        .beat_error       (beat_error),
        .local_mem_addr   (local_mem_addr),
        .local_mem_write  (local_mem_write),
        .local_mem_wdata  (local_mem_wdata),
        .dma_busy         (dma_busy),
        .dma_done         (dma_done),
        .dma_error        (dma_error),
        .dma_head_ptr     (dma_head_ptr)
    );

endmodule
